// File: Makefile
TOOL     = verilator
TOP      = noc_chain_tb
FILELIST = noc_chain.f
FLAGS    = --binary --timing --assert -Wno-fatal --top-module $(TOP)
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --Mdir $(BUILD) -f $(FILELIST)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

// File: hdl/flit_packer.sv
// Flit packer
// Registers a data word into a flit carrying this node's address
`timescale 1ns/1ps
`default_nettype none

module flit_packer #(
    parameter noc_chain_pkg::router_addr_t NODE_ADDR = '0
) (
    input  logic                 clk,
    input  logic                 reset,
    input  noc_chain_pkg::data_t word_in,
    input  logic                 word_valid,
    output noc_chain_pkg::flit_t flit_out
);

    logic                 valid_q;
    noc_chain_pkg::data_t data_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= word_valid;
        end
    end

    // Payload only loads with a valid word
    always_ff @(posedge clk) begin
        if (word_valid) begin
            data_q <= word_in;
        end
    end

    always_comb begin
        flit_out.valid = valid_q;
        flit_out.src   = NODE_ADDR;   // Header stamp
        flit_out.data  = data_q;
    end

endmodule

`default_nettype wire

// File: hdl/link_controller.sv
// Link controller
// Paces word issue at one in two cycles and counts the words in flight
`timescale 1ns/1ps
`default_nettype none

module link_controller (
    input  logic clk,
    input  logic reset,
    input  logic enable,   // Level request for words
    input  logic retire,   // Word left the chain
    output logic accept,   // One-cycle issue strobe
    output logic busy
);

    // Enough room for every word that could sit in the pipe
    localparam int CNT_W = $clog2(noc_chain_pkg::PIPE_DEPTH + 1);

    noc_chain_pkg::link_state_t state;
    noc_chain_pkg::link_state_t state_next;
    logic [CNT_W-1:0] in_flight;

    // Issue in IDLE or ISSUE but never in GAP
    assign accept = enable && (state != noc_chain_pkg::GAP);

    always_comb begin
        state_next = state;
        case (state)
            noc_chain_pkg::IDLE: begin
                if (enable) begin
                    state_next = noc_chain_pkg::GAP;
                end
            end
            noc_chain_pkg::ISSUE: begin
                if (enable) begin
                    state_next = noc_chain_pkg::GAP;
                end else begin
                    state_next = noc_chain_pkg::IDLE;   // Request withdrawn
                end
            end
            noc_chain_pkg::GAP: begin
                if (enable) begin
                    state_next = noc_chain_pkg::ISSUE;
                end else begin
                    state_next = noc_chain_pkg::IDLE;
                end
            end
            default: state_next = noc_chain_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= noc_chain_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Accept and retire in one cycle cancel out
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            in_flight <= '0;
        end else if (accept && !retire) begin
            in_flight <= in_flight + 1'b1;
        end else if (retire && !accept) begin
            in_flight <= in_flight - 1'b1;
        end
    end

    assign busy = (in_flight != '0);

endmodule

`default_nettype wire

// File: hdl/noc_chain_pkg.sv
// noc_chain shared definitions
// Widths, router addresses, flit layout and link controller states
`default_nettype none

package noc_chain_pkg;

    localparam int DATA_W = 64;               // One flit payload word
    localparam int SUM_W  = 2 * DATA_W;       // Accumulator width
    localparam int ADDR_W = 4;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [SUM_W-1:0]  sum_t;
    typedef logic [ADDR_W-1:0] router_addr_t;

    localparam router_addr_t NODE1_ADDR = 4'd1;
    localparam router_addr_t NODE2_ADDR = 4'd2;
    localparam router_addr_t NODE3_ADDR = 4'd3;

    // Cycles from accept strobe to data_valid
    // One in the source, three in the packers and three in the accumulators
    localparam int PIPE_DEPTH = 7;

    // One 69-bit hop on the chain
    typedef struct packed {
        logic         valid;
        router_addr_t src;  // Address of the sending router
        data_t        data;
    } flit_t;

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        GAP
    } link_state_t;

endpackage

`default_nettype wire

// File: hdl/noc_chain_top.sv
// Four-node NoC chain top level
// Source and node 1 packer feed accumulating nodes 2 to 4, paced by the link controller
`timescale 1ns/1ps
`default_nettype none

module noc_chain_top #(
    parameter noc_chain_pkg::router_addr_t NODE1_ADDR = noc_chain_pkg::NODE1_ADDR,
    parameter noc_chain_pkg::router_addr_t NODE2_ADDR = noc_chain_pkg::NODE2_ADDR,
    parameter noc_chain_pkg::router_addr_t NODE3_ADDR = noc_chain_pkg::NODE3_ADDR
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                enable,
    output noc_chain_pkg::sum_t data_out,
    output logic                data_valid,
    output logic                busy,
    output logic                route_error
);

    logic                 accept;
    noc_chain_pkg::data_t src_word;
    logic                 src_valid;

    noc_chain_pkg::flit_t flit_n1;   // Node 1 to node 2
    noc_chain_pkg::flit_t flit_n2;   // Node 2 to node 3
    noc_chain_pkg::flit_t flit_n3;   // Node 3 to node 4

    noc_chain_pkg::sum_t sum_n2;
    noc_chain_pkg::sum_t sum_n3;
    noc_chain_pkg::sum_t sum_n4;
    logic                valid_n2;
    logic                valid_n3;
    logic                valid_n4;
    logic                mismatch_n2;
    logic                mismatch_n3;
    logic                mismatch_n4;

    link_controller u_link_ctrl (
        .clk    (clk),
        .reset  (reset),
        .enable (enable),
        .retire (valid_n4),   // Word reached node 4
        .accept (accept),
        .busy   (busy)
    );

    traffic_source u_source (
        .clk       (clk),
        .reset     (reset),
        .accept    (accept),
        .src_word  (src_word),
        .src_valid (src_valid)
    );

    // Node 1 transmits only
    flit_packer #(.NODE_ADDR(NODE1_ADDR)) u_pack_n1 (
        .clk        (clk),
        .reset      (reset),
        .word_in    (src_word),
        .word_valid (src_valid),
        .flit_out   (flit_n1)
    );

    traffic_accumulator #(.UPSTREAM_ADDR(NODE1_ADDR)) u_acc_n2 (
        .clk       (clk),
        .reset     (reset),
        .flit_in   (flit_n1),
        .sum       (sum_n2),
        .sum_valid (valid_n2),
        .mismatch  (mismatch_n2)
    );

    // Lower word of the running sum goes downstream
    flit_packer #(.NODE_ADDR(NODE2_ADDR)) u_pack_n2 (
        .clk        (clk),
        .reset      (reset),
        .word_in    (sum_n2[noc_chain_pkg::DATA_W-1:0]),
        .word_valid (valid_n2),
        .flit_out   (flit_n2)
    );

    traffic_accumulator #(.UPSTREAM_ADDR(NODE2_ADDR)) u_acc_n3 (
        .clk       (clk),
        .reset     (reset),
        .flit_in   (flit_n2),
        .sum       (sum_n3),
        .sum_valid (valid_n3),
        .mismatch  (mismatch_n3)
    );

    flit_packer #(.NODE_ADDR(NODE3_ADDR)) u_pack_n3 (
        .clk        (clk),
        .reset      (reset),
        .word_in    (sum_n3[noc_chain_pkg::DATA_W-1:0]),
        .word_valid (valid_n3),
        .flit_out   (flit_n3)
    );

    // Node 4 receives only
    traffic_accumulator #(.UPSTREAM_ADDR(NODE3_ADDR)) u_acc_n4 (
        .clk       (clk),
        .reset     (reset),
        .flit_in   (flit_n3),
        .sum       (sum_n4),
        .sum_valid (valid_n4),
        .mismatch  (mismatch_n4)
    );

    assign data_out   = sum_n4;
    assign data_valid = valid_n4;

    // Held until the next reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            route_error <= 1'b0;
        end else if (mismatch_n2 || mismatch_n3 || mismatch_n4) begin
            route_error <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/traffic_accumulator.sv
// Traffic accumulator
// Checks the flit source address and adds accepted flit data into a 128-bit sum
`timescale 1ns/1ps
`default_nettype none

module traffic_accumulator #(
    parameter noc_chain_pkg::router_addr_t UPSTREAM_ADDR = '0
) (
    input  logic                 clk,
    input  logic                 reset,
    input  noc_chain_pkg::flit_t flit_in,
    output noc_chain_pkg::sum_t  sum,
    output logic                 sum_valid,
    output logic                 mismatch
);

    logic                src_ok;
    noc_chain_pkg::sum_t data_ext;

    assign src_ok   = (flit_in.src == UPSTREAM_ADDR);
    assign data_ext = {{noc_chain_pkg::DATA_W{1'b0}}, flit_in.data};   // Zero extend

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sum       <= '0;
            sum_valid <= 1'b0;
            mismatch  <= 1'b0;
        end else begin
            sum_valid <= 1'b0;
            mismatch  <= 1'b0;
            if (flit_in.valid) begin
                if (src_ok) begin
                    sum       <= sum + data_ext;
                    sum_valid <= 1'b1;
                end else begin
                    mismatch  <= 1'b1;   // Wrong sender leaves the sum as it is
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/traffic_source.sv
// Traffic source
// Emits the words 1, 2, 3 ... one per accept strobe
`timescale 1ns/1ps
`default_nettype none

module traffic_source (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 accept,
    output noc_chain_pkg::data_t src_word,
    output logic                 src_valid
);

    noc_chain_pkg::data_t word_next;

    assign word_next = src_word + 1'b1;

    // The output register is the word counter itself
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            src_word  <= '0;
            src_valid <= 1'b0;
        end else begin
            src_valid <= accept;       // Single-cycle pulse
            if (accept) begin
                src_word <= word_next;
            end
        end
    end

endmodule

`default_nettype wire

// File: noc_chain.f
hdl/noc_chain_pkg.sv
hdl/link_controller.sv
hdl/traffic_source.sv
hdl/flit_packer.sv
hdl/traffic_accumulator.sv
hdl/noc_chain_top.sv
sim/noc_chain_assertions.sv
sim/noc_chain_tb.sv

// File: sim/noc_chain_assertions.sv
// Concurrent checks on link pacing, pipe latency and output pulses
// Bound into the chain top level
`timescale 1ns/1ps
`default_nettype none

module noc_chain_assertions (
    input logic clk,
    input logic reset,
    input logic accept,
    input logic data_valid,
    input logic route_error
);

    // Issue at most every second cycle
    accept_spacing: assert property (
        @(posedge clk) disable iff (reset)
        accept |=> !accept
    ) else $error("accept fired in two consecutive cycles");

    pipe_latency: assert property (
        @(posedge clk) disable iff (reset)
        data_valid == $past(accept, noc_chain_pkg::PIPE_DEPTH)
    ) else $error("data_valid not %0d cycles after accept", noc_chain_pkg::PIPE_DEPTH);

    valid_spacing: assert property (
        @(posedge clk) disable iff (reset)
        data_valid |=> !data_valid
    ) else $error("data_valid pulses in adjacent cycles");

    // Sticky until the next reset
    error_sticky: assert property (
        @(posedge clk) disable iff (reset)
        route_error |=> route_error
    ) else $error("route_error fell without a reset");

endmodule

bind noc_chain_top noc_chain_assertions u_chain_assertions (
    .clk         (clk),
    .reset       (reset),
    .accept      (accept),
    .data_valid  (data_valid),
    .route_error (route_error)
);

`default_nettype wire

// File: sim/noc_chain_tb.sv
// Testbench for the four-node NoC chain
// Directed tests against a reference model of the node sums
`timescale 1ns/1ps
`default_nettype none

module noc_chain_tb;

    localparam int RESET_CYCLES   = 10;
    localparam int LATENCY        = 7;     // Enable cycle to data_valid
    localparam int TIMEOUT_CYCLES = 200;

    logic                clk;
    logic                reset;
    logic                enable;
    noc_chain_pkg::sum_t data_out;
    logic                data_valid;
    logic                busy;
    logic                route_error;

    int          error_count;
    int          check_count;
    int          cycle_cnt = 0;
    int          pulses_seen;
    int          words_expected;
    int          pulse_cycles[$];     // Cycle of each data_valid in a test
    logic [31:0] lfsr_state;

    // Reference model state
    noc_chain_pkg::data_t next_word;
    noc_chain_pkg::sum_t  s2;
    noc_chain_pkg::sum_t  s3;
    noc_chain_pkg::sum_t  s4;

    noc_chain_top dut0 (
        .clk         (clk),
        .reset       (reset),
        .enable      (enable),
        .data_out    (data_out),
        .data_valid  (data_valid),
        .busy        (busy),
        .route_error (route_error)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic logic [31:0] galois_step(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'h8020_0003;   // Taps 32, 22, 2, 1
        end
        return next;
    endfunction

    // One LFSR step per bit
    task automatic take_bits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            value = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = galois_step(lfsr_state);
        end
    endtask

    // Next word through nodes 2, 3 and 4
    task automatic advance_model(output noc_chain_pkg::sum_t expected);
        next_word = next_word + 64'd1;
        s2 = s2 + {64'd0, next_word};
        s3 = s3 + {64'd0, s2[63:0]};
        s4 = s4 + {64'd0, s3[63:0]};
        expected = s4;
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        check_count++;
        assert (actual === expected) else begin
            $display("Error at %0d ns: %s expected %0b got %0b", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic compare_sum(input string name, input noc_chain_pkg::sum_t expected,
                               input noc_chain_pkg::sum_t actual);
        check_count++;
        assert (actual === expected) else begin
            $display("Error at %0d ns: %s expected %h got %h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic compare_int(input string name, input int expected, input int actual);
        check_count++;
        assert (actual == expected) else begin
            $display("Error at %0d ns: %s expected %0d got %0d", $time, name, expected, actual);
            error_count++;
        end
    endtask

    // Output monitor sampled mid-cycle
    always @(negedge clk) begin : monitor
        noc_chain_pkg::sum_t expected;
        if (cycle_cnt > RESET_CYCLES) begin
            if (data_valid) begin
                advance_model(expected);
                compare_sum("data_out", expected, data_out);
                check_bit("busy", 1'b1, busy);   // Word still counted in flight
                pulses_seen++;
                pulse_cycles.push_back(cycle_cnt);
            end
            check_bit("route_error", 1'b0, route_error);
        end
    end

    // Enable for len cycles, then low for gap cycles
    task automatic drive_burst(input int len, input int gap);
        enable = 1'b1;
        repeat (len) @(negedge clk);
        enable = 1'b0;
        repeat (gap) @(negedge clk);
        words_expected += (len + 1) / 2;   // One word every second cycle
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (busy && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (busy) begin
            $display("Timeout at %0d ns: busy did not fall after the last word", $time);
            error_count++;
        end else if (pulse_cycles.size() > 0) begin
            compare_int("busy fall cycle", pulse_cycles[$] + 1, cycle_cnt);
        end
        repeat (2) @(negedge clk);         // Room for any stray pulse
        compare_int("data_valid count", words_expected, pulses_seen);
        check_bit("route_error", 1'b0, route_error);
    endtask

    task automatic after_reset();
        check_bit("data_valid", 1'b0, data_valid);
        check_bit("busy", 1'b0, busy);
        check_bit("route_error", 1'b0, route_error);
        compare_sum("data_out", 128'd0, data_out);
    endtask

    task automatic single_word();
        int start;
        int waited;
        pulse_cycles.delete();
        start = cycle_cnt;
        enable = 1'b1;
        @(negedge clk);
        enable = 1'b0;
        words_expected++;
        check_bit("busy", 1'b1, busy);
        waited = 0;
        while (!data_valid && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (!data_valid) begin
            $display("Timeout at %0d ns: no data_valid for the single word", $time);
            error_count++;
        end else begin
            compare_int("data_valid latency", LATENCY, cycle_cnt - start);
            compare_sum("data_out", 128'd1, data_out);
        end
        wait_drain();
    endtask

    task automatic held_enable(input int len);
        pulse_cycles.delete();
        drive_burst(len, 1);
        wait_drain();
        compare_int("pulses in burst", (len + 1) / 2, pulse_cycles.size());
        for (int i = 1; i < pulse_cycles.size(); i++) begin
            compare_int("pulse spacing", 2, pulse_cycles[i] - pulse_cycles[i - 1]);
        end
    endtask

    task automatic random_bursts(input int bursts);
        int len;
        int gap;
        pulse_cycles.delete();
        for (int b = 0; b < bursts; b++) begin
            take_bits(3, len);
            take_bits(2, gap);
            drive_burst(len + 1, gap + 1);   // Bursts of 1 to 8, gaps of 1 to 4
        end
        wait_drain();
    endtask

    initial begin
        reset          = 1'b1;
        enable         = 1'b0;
        error_count    = 0;
        check_count    = 0;
        pulses_seen    = 0;
        words_expected = 0;
        lfsr_state     = 32'hf1d;
        next_word      = '0;
        s2             = '0;
        s3             = '0;
        s4             = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        after_reset();
        single_word();
        held_enable(6);
        held_enable(5);
        random_bursts(12);

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
